/* sim.f */
design/busPkg.sv
design/busCtrlIf.sv
design/busFsm.sv
design/fetchBuffer.sv
design/busDp.sv
dv/busMemModel.sv
dv/busDpTb.sv

/* dv/busDpTb.sv */
// Testbench for the load/store bus unit
// Clock, reset, LFSR stimulus, line and uncached transfers, protocol checks,
// watchdog and final report

`timescale 1ns/1ps

module busDpTb;

  localparam int           wordsPerLine    = 4;
  localparam busPkg::wordT patKey          = 32'h5a3c_96e1;
  localparam logic [31:0]  lfsrSeed        = 32'hb2eee593;
  localparam int           resetCycles     = 10;
  // Reset check plus five transfer tests
  localparam int           testCount       = 6;
  // Slave delay of 3 plus four handshake edges, rounded up
  localparam int           worstBeatCycles = 8;
  localparam int           timeoutCycles   =
    testCount * wordsPerLine * worstBeatCycles * 2 + resetCycles;

  logic                            clk;
  logic                            rstN;
  busPkg::wordT                    busRdata;
  logic                            busAck;
  logic                            busReq;
  logic                            busRead;
  logic                            busWrite;
  busPkg::pAdrT                    busAdr;
  busPkg::busSizeT                 busSize;
  busPkg::wordT                    busWdata;
  busPkg::pAdrT                    cacheBusAdr;
  busPkg::wordT [wordsPerLine-1:0] writeLineData;
  logic                            fetchLine;
  logic                            writeLine;
  logic                            lineAck;
  busPkg::wordT [wordsPerLine-1:0] lineData;
  busPkg::pAdrT                    pAdr;
  busPkg::busSizeT                 funct3;
  busPkg::wordT                    writeData;
  busPkg::wordT                    cacheReadWord;
  busPkg::wordT                    readWord;
  logic [1:0]                      rw;
  logic                            ignoreRequest;
  logic                            cpuBusy;
  logic                            cacheable;
  logic                            busStall;
  logic                            busCommitted;
  logic [1:0]                      ackDelay;

  int                              errorCount;
  int                              checkCount;
  int                              testsRun;
  int                              cycleCount;
  logic [31:0]                     lfsrState;

  // Every acknowledged beat, as seen on the bus
  busPkg::pAdrT                    beatAdr[$];
  busPkg::busSizeT                 beatSize[$];
  logic                            beatWr[$];

  busDp #(.wordsPerLine(wordsPerLine)) u_dut (.*);

  busMemModel #(.patKey(patKey)) u_mem (.*);

  ////////////////////
  // Clock and helpers
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      value     = {value[30:0], fb};
    end
    return value;
  endfunction

  // The slave returns the word address XOR the key
  function automatic busPkg::wordT expectedWord(input busPkg::pAdrT adr);
    return {2'b00, adr[31:2]} ^ patKey;
  endfunction

  task automatic expectValue(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finishTest(input string name, input int startErrors);
    testsRun++;
    $display("test %-14s %s (%0d errors)", name,
             (errorCount == startErrors) ? "ok" : "failed", errorCount - startErrors);
  endtask

  task automatic clearBeats();
    beatAdr.delete();
    beatSize.delete();
    beatWr.delete();
  endtask

  task automatic waitLineAck();
    do @(posedge clk); while (lineAck !== 1'b1);
  endtask

  // Returns in the first cycle after the stall has dropped again
  task automatic waitStallPulse();
    do @(posedge clk); while (busStall !== 1'b1);
    do @(posedge clk); while (busStall !== 1'b0);
  endtask

  // A fresh slave delay of 0 to 3 cycles every clock
  always @(posedge clk) begin
    ackDelay <= randBits(2);
  end

  // Ack is high for one edge while req is still up, so each beat logs once
  always @(posedge clk) begin
    if (rstN && busReq && busAck) begin
      beatAdr.push_back(busAdr);
      beatSize.push_back(busSize);
      beatWr.push_back(busWrite);
    end
  end

  ////////////////////
  // Protocol checks
  ////////////////////

  reqDropsAfterAck: assert property (@(posedge clk) disable iff (!rstN)
    $fell(busReq) |-> $past(busAck)) else begin
    errorCount++;
    $display("Protocol error at %0t: busReq fell before busAck was seen", $time);
  end

  reqRisesAckLow: assert property (@(posedge clk) disable iff (!rstN)
    $rose(busReq) |-> !busAck) else begin
    errorCount++;
    $display("Protocol error at %0t: busReq rose while busAck was high", $time);
  end

  beatHeld: assert property (@(posedge clk) disable iff (!rstN)
    (busReq && $past(busReq)) |->
      ($stable(busAdr) && $stable(busSize) && $stable(busWdata))) else begin
    errorCount++;
    $display("Protocol error at %0t: beat changed while busReq was high", $time);
  end

  reqCommitted: assert property (@(posedge clk) disable iff (!rstN)
    busReq |-> busCommitted) else begin
    errorCount++;
    $display("Protocol error at %0t: busReq high without busCommitted", $time);
  end

  ////////////////////
  // Tests
  ////////////////////

  task automatic checkResetState();
    int startErrors;
    startErrors = errorCount;
    @(posedge clk);
    expectValue("busReq after reset", busReq, 1'b0);
    expectValue("busCommitted after reset", busCommitted, 1'b0);
    expectValue("busStall after reset", busStall, 1'b0);
    expectValue("lineAck after reset", lineAck, 1'b0);
    expectValue("busRead after reset", busRead, 1'b0);
    expectValue("busWrite after reset", busWrite, 1'b0);
    finishTest("reset", startErrors);
  endtask

  task automatic fetchCachedLine();
    busPkg::pAdrT base;
    int           startErrors;
    startErrors = errorCount;
    base = randBits(28) << 4;
    clearBeats();
    @(posedge clk);
    cacheBusAdr <= base;
    fetchLine   <= 1'b1;
    waitLineAck();
    fetchLine <= 1'b0;
    expectValue("fetch beat count", beatAdr.size(), wordsPerLine);
    for (int i = 0; i < beatAdr.size(); i++) begin
      expectValue("fetch beat address", beatAdr[i], base + busPkg::pAdrT'(4 * i));
      expectValue("fetch beat size", beatSize[i], busPkg::sizeWord);
      expectValue("fetch beat kind", beatWr[i], 1'b0);
    end
    // The line is already complete in the lineAck cycle
    for (int i = 0; i < wordsPerLine; i++) begin
      expectValue("fetched line word", lineData[i],
                  expectedWord(base + busPkg::pAdrT'(4 * i)));
    end
    finishTest("line fetch", startErrors);
  endtask

  task automatic writeBackLine();
    busPkg::pAdrT                    base;
    busPkg::wordT [wordsPerLine-1:0] words;
    int                              logStart;
    int                              startErrors;
    startErrors = errorCount;
    base = randBits(28) << 4;
    for (int i = 0; i < wordsPerLine; i++) begin
      words[i] = randBits(32);
    end
    logStart = u_mem.logCount;
    @(posedge clk);
    cacheBusAdr   <= base;
    writeLineData <= words;
    writeLine     <= 1'b1;
    waitLineAck();
    writeLine <= 1'b0;
    expectValue("writeback beat count", u_mem.logCount - logStart, wordsPerLine);
    for (int i = 0; i < wordsPerLine; i++) begin
      expectValue("writeback address", u_mem.logAdr[logStart + i],
                  base + busPkg::pAdrT'(4 * i));
      expectValue("writeback data", u_mem.logData[logStart + i], words[i]);
      expectValue("writeback size", u_mem.logSize[logStart + i], busPkg::sizeWord);
    end
    @(posedge clk);
    expectValue("lineAck one cycle", lineAck, 1'b0);
    finishTest("line writeback", startErrors);
  endtask

  task automatic readUncachedWord();
    busPkg::pAdrT    adr;
    busPkg::busSizeT size;
    int              startErrors;
    startErrors = errorCount;
    adr  = randBits(30) << 2;
    // Byte, half or word load
    size = busPkg::busSizeT'(randBits(2) % 3);
    clearBeats();
    @(posedge clk);
    pAdr      <= adr;
    funct3    <= size;
    rw        <= busPkg::rwReadCode;
    cacheable <= 1'b0;
    cpuBusy   <= 1'b1;
    waitStallPulse();
    expectValue("uncached readWord", readWord, expectedWord(adr));
    // The word must survive while the processor is still busy
    repeat (3) begin
      @(posedge clk);
      expectValue("readWord held", readWord, expectedWord(adr));
      expectValue("stall while held", busStall, 1'b0);
    end
    rw        <= 2'b00;
    cpuBusy   <= 1'b0;
    cacheable <= 1'b1;
    expectValue("uncached read beats", beatAdr.size(), 1);
    expectValue("uncached read address", beatAdr[0], adr);
    expectValue("uncached read size", beatSize[0], size);
    expectValue("uncached read kind", beatWr[0], 1'b0);
    finishTest("uncached read", startErrors);
  endtask

  task automatic storeUncachedWord();
    busPkg::pAdrT    adr;
    busPkg::busSizeT size;
    busPkg::wordT    data;
    busPkg::wordT    cached;
    int              logStart;
    int              startErrors;
    startErrors = errorCount;
    adr      = randBits(30) << 2;
    size     = busPkg::busSizeT'(randBits(2) % 3);
    data     = randBits(32);
    cached   = randBits(32);
    logStart = u_mem.logCount;
    @(posedge clk);
    pAdr          <= adr;
    funct3        <= size;
    writeData     <= data;
    cacheReadWord <= cached;
    rw            <= busPkg::rwWriteCode;
    cacheable     <= 1'b0;
    cpuBusy       <= 1'b0;
    waitStallPulse();
    rw        <= 2'b00;
    cacheable <= 1'b1;
    expectValue("uncached write beats", u_mem.logCount - logStart, 1);
    expectValue("uncached write address", u_mem.logAdr[logStart], adr);
    expectValue("uncached write data", u_mem.logData[logStart], data);
    expectValue("uncached write size", u_mem.logSize[logStart], size);
    // Back in cached mode the processor sees the cache's word
    repeat (2) @(posedge clk);
    expectValue("cached readWord", readWord, cached);
    finishTest("uncached write", startErrors);
  endtask

  task automatic holdOffIgnored();
    int startErrors;
    startErrors = errorCount;
    clearBeats();
    @(posedge clk);
    ignoreRequest <= 1'b1;
    rw            <= busPkg::rwReadCode;
    cacheable     <= 1'b0;
    repeat (8) begin
      @(posedge clk);
      expectValue("busReq while ignored", busReq, 1'b0);
      expectValue("busStall while ignored", busStall, 1'b0);
      expectValue("busCommitted while ignored", busCommitted, 1'b0);
    end
    rw            <= 2'b00;
    ignoreRequest <= 1'b0;
    cacheable     <= 1'b1;
    expectValue("beats while ignored", beatAdr.size(), 0);
    finishTest("ignored request", startErrors);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rstN          = 1'b0;
    cacheBusAdr   = '0;
    writeLineData = '0;
    fetchLine     = 1'b0;
    writeLine     = 1'b0;
    pAdr          = '0;
    funct3        = busPkg::sizeWord;
    writeData     = '0;
    cacheReadWord = '0;
    rw            = 2'b00;
    ignoreRequest = 1'b0;
    cpuBusy       = 1'b0;
    cacheable     = 1'b1;
    ackDelay      = 2'd0;
    lfsrState     = lfsrSeed;
    errorCount    = 0;
    checkCount    = 0;
    testsRun      = 0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    checkResetState();
    fetchCachedLine();
    writeBackLine();
    readUncachedWord();
    storeUncachedWord();
    holdOffIgnored();
    repeat (2) @(posedge clk);
    $display("tests %0d, checks %0d, errors %0d", testsRun, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the test count and the slowest possible beat
  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* dv/busMemModel.sv */
// Four-phase bus slave for the load/store bus unit testbench
// Acknowledges each beat after a delay given by the testbench, returns a
// patterned read word and logs every write beat

`timescale 1ns/1ps

module busMemModel #(
  parameter busPkg::wordT patKey   = 32'h0,
  parameter int           logDepth = 16
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            busReq,
  input  logic            busRead,
  input  logic            busWrite,
  input  busPkg::pAdrT    busAdr,
  input  busPkg::busSizeT busSize,
  input  busPkg::wordT    busWdata,
  input  logic [1:0]      ackDelay,
  output logic            busAck,
  output busPkg::wordT    busRdata
);

  // Write log, read back by the testbench after each transfer
  busPkg::pAdrT    logAdr  [logDepth];
  busPkg::wordT    logData [logDepth];
  busPkg::busSizeT logSize [logDepth];
  int              logCount;

  // Cycles left before the current beat is acknowledged
  logic [1:0]      waitCnt;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busAck   <= 1'b0;
      busRdata <= '0;
      waitCnt  <= '0;
      logCount <= 0;
    end else if (!busReq) begin
      // Request gone, so release ack and pick the delay for the next beat
      busAck  <= 1'b0;
      waitCnt <= ackDelay;
    end else if (!busAck) begin
      if (waitCnt != 2'd0) begin
        waitCnt <= waitCnt - 2'd1;
      end else begin
        busAck <= 1'b1;
        // Read word is the word address mixed with a fixed key
        if (busRead) begin
          busRdata <= {2'b00, busAdr[31:2]} ^ patKey;
        end
        if (busWrite && (logCount < logDepth)) begin
          logAdr[logCount]  <= busAdr;
          logData[logCount] <= busWdata;
          logSize[logCount] <= busSize;
          logCount          <= logCount + 1;
        end
      end
    end
  end

endmodule

/* design/busDp.sv */
// Bus data path, top of the load/store bus unit
// Holds the sequencer and fetch buffer, and muxes bus address, size,
// write data and the word returned to the processor

`timescale 1ns/1ps

module busDp #(
  parameter int wordsPerLine = 4
) (
  input  logic                            clk,
  input  logic                            rstN,

  // Bus side
  input  busPkg::wordT                    busRdata,
  input  logic                            busAck,
  output logic                            busReq,
  output logic                            busRead,
  output logic                            busWrite,
  output busPkg::pAdrT                    busAdr,
  output busPkg::busSizeT                 busSize,
  output busPkg::wordT                    busWdata,

  // Cache side
  input  busPkg::pAdrT                    cacheBusAdr,
  input  busPkg::wordT [wordsPerLine-1:0] writeLineData,
  input  logic                            fetchLine,
  input  logic                            writeLine,
  output logic                            lineAck,
  output busPkg::wordT [wordsPerLine-1:0] lineData,

  // Processor side
  input  busPkg::pAdrT                    pAdr,
  input  busPkg::busSizeT                 funct3,
  input  busPkg::wordT                    writeData,
  input  busPkg::wordT                    cacheReadWord,
  output busPkg::wordT                    readWord,
  input  logic [1:0]                      rw,
  input  logic                            ignoreRequest,
  input  logic                            cpuBusy,
  input  logic                            cacheable,
  output logic                            busStall,
  output logic                            busCommitted
);

  // Base address before the beat offset is added
  busPkg::pAdrT localAdr;
  // Byte offset of the current beat within the line
  busPkg::pAdrT beatOffset;

  // Beat control shared by the three blocks
  busCtrlIf #(.wordsPerLine(wordsPerLine)) ctrlBus ();

  ////////////////////
  // Sequencer
  ////////////////////

  busFsm #(
    .wordsPerLine(wordsPerLine)
  ) u_busFsm (
    .clk          (clk),
    .rstN         (rstN),
    .rw           (rw),
    .ignoreRequest(ignoreRequest),
    .cacheable    (cacheable),
    .cpuBusy      (cpuBusy),
    .fetchLine    (fetchLine),
    .writeLine    (writeLine),
    .busAck       (busAck),
    .ctrl         (ctrlBus.seq),
    .busStall     (busStall),
    .busCommitted (busCommitted),
    .lineAck      (lineAck)
  );

  ////////////////////
  // Fetch buffer
  ////////////////////

  // Captures every read beat, line words and the uncached word alike
  fetchBuffer #(
    .wordsPerLine(wordsPerLine)
  ) u_fetchBuffer (
    .clk     (clk),
    .rstN    (rstN),
    .ctrl    (ctrlBus.fbuf),
    .busRdata(busRdata),
    .lineData(lineData)
  );

  ////////////////////
  // Bus request
  ////////////////////

  assign busReq   = ctrlBus.beatReq;
  assign busRead  = ctrlBus.busRead;
  assign busWrite = ctrlBus.busWrite;

  ////////////////////
  // Address and size
  ////////////////////

  // Uncached beats go straight to the processor address
  assign localAdr = ctrlBus.selUncached ? pAdr : cacheBusAdr;

  // The beat count is held at zero for uncached transfers, so the
  // offset only moves through a line
  assign beatOffset = busPkg::pAdrT'(ctrlBus.wordCount) << busPkg::wordBytesLog;

  assign busAdr = localAdr + beatOffset;

  // Line beats are always full words, uncached beats keep the access size
  assign busSize = ctrlBus.selUncached ? funct3 : busPkg::sizeWord;

  ////////////////////
  // Data muxes
  ////////////////////

  // Writeback walks the dirty line one word per beat
  assign busWdata = ctrlBus.selUncached ? writeData : writeLineData[ctrlBus.wordCount];

  // An uncached read returns the word held in fetch buffer slot 0
  assign readWord = ctrlBus.selUncached ? lineData[0] : cacheReadWord;

  ////////////////////
  // Checks
  ////////////////////

  // The slave may sample the beat at any point while req is high, so
  // the sequencer state and the muxed inputs together must hold still
  beatStable: assert property (@(posedge clk) disable iff (!rstN)
    (busReq && $past(busReq)) |->
      ($stable(busAdr) && $stable(busSize) && $stable(busWdata) &&
       $stable(busRead) && $stable(busWrite)));

  // Exactly one transfer kind is named whenever a beat is requested
  beatKind: assert property (@(posedge clk) disable iff (!rstN)
    busReq |-> (busRead ^ busWrite));

endmodule

/* design/fetchBuffer.sv */
// Fetch buffer that gathers read beats into a cache line
// Word 0 doubles as the holding register for uncached reads

`timescale 1ns/1ps

module fetchBuffer #(
  parameter int wordsPerLine = 4
) (
  input  logic                                clk,
  input  logic                                rstN,
  busCtrlIf.fbuf                              ctrl,
  input  busPkg::wordT                        busRdata,
  output busPkg::wordT [wordsPerLine-1:0]     lineData
);

  // Line width in bits, for the flat view of the buffer
  localparam int lineBits = wordsPerLine * $bits(busPkg::wordT);

  // Per-word load enables decoded from the beat index
  logic [wordsPerLine-1:0] loadEn;
  // Flat view of the captured line
  logic [lineBits-1:0]     lineFlat;

  ////////////////////
  // Word registers
  ////////////////////

  for (genvar i = 0; i < wordsPerLine; i++) begin : gWord
    // Only the word addressed by the current beat loads
    assign loadEn[i] = ctrl.captureEn && (int'(ctrl.wordCount) == i);

    // Each word keeps its value until its next read beat
    always_ff @(posedge clk) begin
      if (loadEn[i]) begin
        lineFlat[i*$bits(busPkg::wordT) +: $bits(busPkg::wordT)] <= busRdata;
      end
    end
  end

  // Word i of the line sits at bits [32i+31:32i]
  assign lineData = lineFlat;

  ////////////////////
  // Checks
  ////////////////////

  // The sequencer must never count a beat past the end of the line
  captureInLine: assert property (@(posedge clk) disable iff (!rstN)
    ctrl.captureEn |-> (int'(ctrl.wordCount) < wordsPerLine));

endmodule

/* design/busFsm.sv */
// Bus sequencer for cached line transfers and uncached single beats
// Runs the four-phase handshake per beat, counts beats,
// and drives stall, commit and the cache line acknowledge

`timescale 1ns/1ps

module busFsm #(
  parameter int wordsPerLine = 4
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic [1:0] rw,
  input  logic       ignoreRequest,
  input  logic       cacheable,
  input  logic       cpuBusy,
  input  logic       fetchLine,
  input  logic       writeLine,
  input  logic       busAck,
  busCtrlIf.seq      ctrl,
  output logic       busStall,
  output logic       busCommitted,
  output logic       lineAck
);

  localparam int countW = (wordsPerLine > 1) ? $clog2(wordsPerLine) : 1;
  // Index of the final beat of a line
  localparam logic [countW-1:0] lastIdx = countW'(wordsPerLine - 1);

  busPkg::busStateT  state;
  busPkg::busStateT  nextState;

  logic [countW-1:0] wordCount;
  logic              selUncached;
  logic              busRead;
  logic              busWrite;

  logic              uncReq;
  logic              startUnc;
  logic              startWrite;
  logic              startFetch;
  logic              startAny;
  logic              lastBeat;

  ////////////////////
  // Request selection
  ////////////////////

  // An uncached access is any read or write the cache will not take
  assign uncReq = !cacheable &&
                  ((rw == busPkg::rwReadCode) || (rw == busPkg::rwWriteCode));

  // A dirty line goes out before a new line comes in
  assign startUnc   = !ignoreRequest && uncReq;
  assign startWrite = !ignoreRequest && !uncReq && writeLine;
  assign startFetch = !ignoreRequest && !uncReq && !writeLine && fetchLine;
  assign startAny   = startUnc || startWrite || startFetch;

  // Uncached transfers are a single beat
  assign lastBeat = selUncached || (wordCount == lastIdx);

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    nextState = state;
    case (state)
      busPkg::stIdle: begin
        if (startAny) begin
          nextState = busPkg::stReqHigh;
        end
      end
      busPkg::stReqHigh: begin
        // Request drops in the cycle after the acknowledge is seen
        if (busAck) begin
          nextState = busPkg::stReqLow;
        end
      end
      busPkg::stReqLow: begin
        // Slave has released ack, so the next beat may start
        if (!busAck) begin
          if (!lastBeat) begin
            nextState = busPkg::stReqHigh;
          end else if (selUncached) begin
            nextState = busPkg::stUncDone;
          end else begin
            nextState = busPkg::stLineDone;
          end
        end
      end
      busPkg::stLineDone: begin
        nextState = busPkg::stIdle;
      end
      busPkg::stUncDone: begin
        // Keep the read word on readWord until the processor moves on
        if (!cpuBusy) begin
          nextState = busPkg::stIdle;
        end
      end
      default: begin
        nextState = busPkg::stIdle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state       <= busPkg::stIdle;
      wordCount   <= '0;
      selUncached <= 1'b0;
      busRead     <= 1'b0;
      busWrite    <= 1'b0;
    end else begin
      state <= nextState;
      case (state)
        busPkg::stIdle: begin
          // Every transfer starts from beat zero
          wordCount <= '0;
          if (startUnc) begin
            selUncached <= 1'b1;
            busRead     <= (rw == busPkg::rwReadCode);
            busWrite    <= (rw == busPkg::rwWriteCode);
          end else if (startWrite) begin
            busWrite <= 1'b1;
          end else if (startFetch) begin
            busRead <= 1'b1;
          end
        end
        busPkg::stReqLow: begin
          if (!busAck) begin
            if (!lastBeat) begin
              wordCount <= wordCount + 1'b1;
            end else begin
              busRead  <= 1'b0;
              busWrite <= 1'b0;
            end
          end
        end
        busPkg::stUncDone: begin
          if (!cpuBusy) begin
            selUncached <= 1'b0;
          end
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign ctrl.wordCount   = wordCount;
  assign ctrl.selUncached = selUncached;
  assign ctrl.busRead     = busRead;
  assign ctrl.busWrite    = busWrite;
  assign ctrl.beatReq     = (state == busPkg::stReqHigh);

  // Read data is only valid while ack is high, so capture right then
  assign ctrl.captureEn = (state == busPkg::stReqHigh) && busAck && busRead;

  // Stall from the request cycle until the last beat has closed
  assign busStall = ((state == busPkg::stIdle) && startAny) ||
                    (state == busPkg::stReqHigh) || (state == busPkg::stReqLow);

  // Once the first beat is requested the access can no longer be dropped
  assign busCommitted = (state != busPkg::stIdle);

  assign lineAck = (state == busPkg::stLineDone);

  ////////////////////
  // Checks
  ////////////////////

  // The request may only fall once the slave has acknowledged it
  reqHeldToAck: assert property (@(posedge clk) disable iff (!rstN)
    $fell(ctrl.beatReq) |-> $past(busAck));

  // A new beat waits for the previous acknowledge to clear
  reqAfterAckLow: assert property (@(posedge clk) disable iff (!rstN)
    $rose(ctrl.beatReq) |-> !busAck);

  // The cache sees exactly one acknowledge per line
  lineAckPulse: assert property (@(posedge clk) disable iff (!rstN)
    lineAck |=> !lineAck);

endmodule

/* design/busCtrlIf.sv */
// Beat control bundle between the bus sequencer, the fetch buffer
// and the bus data path, with one modport per user

`timescale 1ns/1ps

interface busCtrlIf #(
  parameter int wordsPerLine = 4
);

  // Beat counter width follows the line length
  localparam int countW = (wordsPerLine > 1) ? $clog2(wordsPerLine) : 1;

  // Index of the beat currently on the bus
  logic [countW-1:0] wordCount;
  // High in the cycle a read beat is acknowledged
  logic              captureEn;
  // The current transfer uses the processor address and size
  logic              selUncached;
  // Kind of transfer in progress
  logic              busRead;
  logic              busWrite;
  // Four-phase bus request
  logic              beatReq;

  // Sequencer owns every member
  modport seq (output wordCount, captureEn, selUncached, busRead, busWrite, beatReq);

  // Fetch buffer only needs to know where and when to capture
  modport fbuf (input wordCount, captureEn);

  // Data path reads the whole bundle
  modport dp (input wordCount, captureEn, selUncached, busRead, busWrite, beatReq);

endinterface

/* design/busPkg.sv */
// Shared types and constants for the load/store bus unit
// Word, address and access-size types, bus size codes, rw codes
// and the bus sequencer state encoding

package busPkg;

  ////////////////////
  // Data widths
  ////////////////////

  // One bus and processor word
  typedef logic [31:0] wordT;

  // Physical byte address
  typedef logic [31:0] pAdrT;

  // Access size, encoded the same way as the load/store funct3 field
  typedef logic [2:0] busSizeT;

  ////////////////////
  // Size codes
  ////////////////////

  // Cached beats always move a full word
  localparam busSizeT sizeWord = 3'b010;

  // Bytes per word as a shift amount, turns a beat index into a byte offset
  localparam int wordBytesLog = 2;

  ////////////////////
  // Processor request
  ////////////////////

  // The memory stage encodes its request as {read, write}
  localparam logic [1:0] rwReadCode  = 2'b10;
  localparam logic [1:0] rwWriteCode = 2'b01;

  ////////////////////
  // Sequencer states
  ////////////////////

  // One pass through stReqHigh and stReqLow is one four-phase beat
  typedef enum logic [2:0] {
    stIdle,
    // Request high, waiting for the slave to acknowledge
    stReqHigh,
    // Request dropped, waiting for the acknowledge to drop
    stReqLow,
    // Last line beat finished, acknowledge the cache
    stLineDone,
    // Uncached beat finished, hold the read word for the processor
    stUncDone
  } busStateT;

endpackage
